// ==== rtl/dmem_pkg.sv ====
// Data-memory path package with shared widths, memory depth and queue depth
`default_nettype none

package dmem_pkg;

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////

  // Data and byte address width, one word
  localparam int XLEN = 32;

  // One enable per byte lane
  localparam int BE_W = XLEN / 8;

  // Byte offset bits inside a word
  localparam int ADR_LSB = $clog2(BE_W);

  ////////////////////////////////////////
  // Memory and queue
  ////////////////////////////////////////

  // SRAM depth in words
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  // Bus command queue, plus one command in the SRAM stage
  localparam int QUEUE_DEPTH = 2;
  localparam int Q_PTR_W     = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int Q_CNT_W     = $clog2(QUEUE_DEPTH + 1);

  // Posted-write counter, holds up to 3 writes in flight
  localparam int PEND_W = 2;

endpackage

`default_nettype wire

// ==== rtl/dmem_sram.sv ====
// Word-wide data SRAM with byte-lane write enables and registered read
`timescale 1ns/1ps
`default_nettype none

module dmem_sram (
  input  wire                          clk,
  input  wire                          sram_en,
  input  wire                          sram_we,
  input  wire  [dmem_pkg::MEM_AW-1:0]  sram_addr,
  input  wire  [dmem_pkg::BE_W-1:0]    sram_be,
  input  wire  [dmem_pkg::XLEN-1:0]    sram_wdata,
  output logic [dmem_pkg::XLEN-1:0]    sram_rdata
);

  import dmem_pkg::*;

  // Storage array
  logic [XLEN-1:0] mem [MEM_WORDS];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Only enabled byte lanes change, others keep old data
  always_ff @(posedge clk)
  begin
    if (sram_en && sram_we)
    begin
      for (int i = 0; i < BE_W; i++)
      begin
        if (sram_be[i])
          mem[sram_addr][8*i +: 8] <= sram_wdata[8*i +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Data shows up the cycle after the access
  always_ff @(posedge clk)
  begin
    if (sram_en && !sram_we)
      sram_rdata <= mem[sram_addr];
  end

endmodule

`default_nettype wire

// ==== rtl/dmem_biu.sv ====
// Bus interface: command queue, SRAM sequencing and in-order completion pulses
`timescale 1ns/1ps
`default_nettype none

module dmem_biu (
  input  wire                          clk,
  input  wire                          rstn,

  // Controller side
  input  wire                          biu_stb,
  input  wire                          biu_we,
  input  wire  [dmem_pkg::XLEN-1:0]    biu_adri,
  input  wire  [dmem_pkg::BE_W-1:0]    biu_be,
  input  wire  [dmem_pkg::XLEN-1:0]    biu_di,
  output logic                         biu_stb_ack,
  output logic                         biu_wack,
  output logic                         biu_rack,
  output logic [dmem_pkg::XLEN-1:0]    biu_do,

  // SRAM side
  output logic                         sram_en,
  output logic                         sram_we,
  output logic [dmem_pkg::MEM_AW-1:0]  sram_addr,
  output logic [dmem_pkg::BE_W-1:0]    sram_be,
  output logic [dmem_pkg::XLEN-1:0]    sram_wdata,
  input  wire  [dmem_pkg::XLEN-1:0]    sram_rdata
);

  import dmem_pkg::*;

  // Command storage
  logic               q_we   [QUEUE_DEPTH];
  logic [MEM_AW-1:0]  q_addr [QUEUE_DEPTH];
  logic [BE_W-1:0]    q_be   [QUEUE_DEPTH];
  logic [XLEN-1:0]    q_data [QUEUE_DEPTH];

  logic [Q_PTR_W-1:0] wr_ptr;
  logic [Q_PTR_W-1:0] rd_ptr;
  logic [Q_CNT_W-1:0] q_cnt;
  logic               q_full;
  logic               q_empty;
  logic               q_push;
  logic               q_pop;

  ////////////////////////////////////////
  // Command queue
  ////////////////////////////////////////

  assign q_full  = (q_cnt == Q_CNT_W'(QUEUE_DEPTH));
  assign q_empty = (q_cnt == '0);

  // Accept whenever there is room
  assign biu_stb_ack = ~q_full;
  assign q_push      = biu_stb & ~q_full;

  // Head goes to the SRAM every cycle it is valid
  assign q_pop = ~q_empty;

  // Byte address reduced to a word address on entry
  always_ff @(posedge clk)
  begin
    if (q_push)
    begin
      q_we[wr_ptr]   <= biu_we;
      q_addr[wr_ptr] <= biu_adri[MEM_AW+ADR_LSB-1:ADR_LSB];
      q_be[wr_ptr]   <= biu_be;
      q_data[wr_ptr] <= biu_di;
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end
    else
    begin
      if (q_push)
        wr_ptr <= (wr_ptr == Q_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + Q_PTR_W'(1);
      if (q_pop)
        rd_ptr <= (rd_ptr == Q_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + Q_PTR_W'(1);
      case ({q_push, q_pop})
        2'b10:   q_cnt <= q_cnt + Q_CNT_W'(1);
        2'b01:   q_cnt <= q_cnt - Q_CNT_W'(1);
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // SRAM access and completion
  ////////////////////////////////////////

  assign sram_en    = q_pop;
  assign sram_we    = q_we[rd_ptr];
  assign sram_addr  = q_addr[rd_ptr];
  assign sram_be    = q_be[rd_ptr];
  assign sram_wdata = q_data[rd_ptr];

  // One done pulse per access, a cycle later
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      biu_wack <= 1'b0;
      biu_rack <= 1'b0;
    end
    else
    begin
      biu_wack <= q_pop & q_we[rd_ptr];
      biu_rack <= q_pop & ~q_we[rd_ptr];
    end
  end

  // Registered SRAM output lines up with biu_rack
  assign biu_do = sram_rdata;

endmodule

`default_nettype wire

// ==== rtl/dmem_nocache_ctrl.sv ====
// No-cache data controller: holds CPU requests, posts writes, blocks reads
`timescale 1ns/1ps
`default_nettype none

module dmem_nocache_ctrl (
  input  wire                         clk,
  input  wire                         rstn,

  // CPU side
  input  wire                         mem_req,
  input  wire                         mem_we,
  input  wire  [dmem_pkg::XLEN-1:0]   mem_adr,
  input  wire  [dmem_pkg::XLEN-1:0]   mem_d,
  input  wire  [dmem_pkg::BE_W-1:0]   mem_be,
  output logic [dmem_pkg::XLEN-1:0]   mem_q,
  output logic                        mem_ack,

  // Bus interface side
  output logic                        biu_stb,
  output logic                        biu_we,
  output logic [dmem_pkg::XLEN-1:0]   biu_adri,
  output logic [dmem_pkg::BE_W-1:0]   biu_be,
  output logic [dmem_pkg::XLEN-1:0]   biu_di,
  input  wire                         biu_stb_ack,
  input  wire                         biu_wack,
  input  wire                         biu_rack,
  input  wire  [dmem_pkg::XLEN-1:0]   biu_do
);

  import dmem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    WAIT4ACK,
    READ
  } state_t;

  state_t            state;

  // Held copy of a request the bus has not taken yet
  logic              hold_req;
  logic              hold_we;
  logic [XLEN-1:0]   hold_adr;
  logic [XLEN-1:0]   hold_d;
  logic [BE_W-1:0]   hold_be;

  logic              req_v;
  logic              accept;
  logic              last_wack;
  logic [PEND_W-1:0] pend_cnt;

  ////////////////////////////////////////
  // Request hold
  ////////////////////////////////////////

  // Payload captured on every strobe
  always_ff @(posedge clk)
  begin
    if (mem_req)
    begin
      hold_we  <= mem_we;
      hold_adr <= mem_adr;
      hold_d   <= mem_d;
      hold_be  <= mem_be;
    end
  end

  // Request stays live until the bus takes it
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      hold_req <= 1'b0;
    else
      hold_req <= req_v & ~accept;
  end

  assign req_v  = mem_req | hold_req;
  assign accept = biu_stb & biu_stb_ack;

  // Held values win, fresh strobe goes straight through
  assign biu_we   = hold_req ? hold_we  : mem_we;
  assign biu_adri = hold_req ? hold_adr : mem_adr;
  assign biu_be   = hold_req ? hold_be  : mem_be;
  assign biu_di   = hold_req ? hold_d   : mem_d;

  ////////////////////////////////////////
  // Posted-write tracking
  ////////////////////////////////////////

  // Up on each accepted write, down on each write-done
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      pend_cnt <= '0;
    else
      case ({accept & biu_we, biu_wack})
        2'b10:   pend_cnt <= pend_cnt + PEND_W'(1);
        2'b01:   pend_cnt <= pend_cnt - PEND_W'(1);
        default: pend_cnt <= pend_cnt;
      endcase
  end

  // Last outstanding write finishes this cycle
  assign last_wack = biu_wack & (pend_cnt == PEND_W'(1));

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state   <= IDLE;
      mem_ack <= 1'b0;
    end
    else
    begin
      mem_ack <= 1'b0;
      case (state)
        // Nothing in flight, queue empty
        IDLE:
          if (accept)
          begin
            if (biu_we)
            begin
              state   <= WRITE;
              mem_ack <= 1'b1;
            end
            else
              state <= READ;
          end

        // Posted writes outstanding
        WRITE:
          if (accept)
          begin
            if (biu_we)
              mem_ack <= 1'b1;
            else
              state <= READ;
          end
          else if (req_v && !biu_we)
            state <= WAIT4ACK;
          else if (!req_v && last_wack)
            state <= IDLE;

        // Read parked until the writes drain
        WAIT4ACK:
          if (accept)
            state <= READ;

        // Read issued, wait for its data
        READ:
          if (biu_rack)
          begin
            mem_ack <= 1'b1;
            state   <= IDLE;
          end

        default: state <= IDLE;
      endcase
    end
  end

  // Read data for the CPU
  always_ff @(posedge clk)
  begin
    if (state == READ && biu_rack)
      mem_q <= biu_do;
  end

  // Reads only go out once no write is left in flight
  always_comb
  begin
    case (state)
      IDLE:     biu_stb = req_v;
      WRITE:    biu_stb = req_v & (biu_we | last_wack);
      WAIT4ACK: biu_stb = req_v & last_wack;
      default:  biu_stb = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dmem_sys.sv ====
// Data-memory subsystem top: no-cache controller, bus interface and SRAM
`timescale 1ns/1ps
`default_nettype none

module dmem_sys (
  input  wire                         clk,
  input  wire                         rstn,

  // CPU data port
  input  wire                         mem_req,
  input  wire                         mem_we,
  input  wire  [dmem_pkg::XLEN-1:0]   mem_adr,
  input  wire  [dmem_pkg::XLEN-1:0]   mem_d,
  input  wire  [dmem_pkg::BE_W-1:0]   mem_be,
  output logic [dmem_pkg::XLEN-1:0]   mem_q,
  output logic                        mem_ack
);

  import dmem_pkg::*;

  // Controller to bus interface
  logic              biu_stb;
  logic              biu_we;
  logic [XLEN-1:0]   biu_adri;
  logic [BE_W-1:0]   biu_be;
  logic [XLEN-1:0]   biu_di;
  logic              biu_stb_ack;
  logic              biu_wack;
  logic              biu_rack;
  logic [XLEN-1:0]   biu_do;

  // Bus interface to SRAM
  logic              sram_en;
  logic              sram_we;
  logic [MEM_AW-1:0] sram_addr;
  logic [BE_W-1:0]   sram_be;
  logic [XLEN-1:0]   sram_wdata;
  logic [XLEN-1:0]   sram_rdata;

  dmem_nocache_ctrl u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_adr     (mem_adr),
    .mem_d       (mem_d),
    .mem_be      (mem_be),
    .mem_q       (mem_q),
    .mem_ack     (mem_ack),
    .biu_stb     (biu_stb),
    .biu_we      (biu_we),
    .biu_adri    (biu_adri),
    .biu_be      (biu_be),
    .biu_di      (biu_di),
    .biu_stb_ack (biu_stb_ack),
    .biu_wack    (biu_wack),
    .biu_rack    (biu_rack),
    .biu_do      (biu_do)
  );

  dmem_biu u_biu (
    .clk         (clk),
    .rstn        (rstn),
    .biu_stb     (biu_stb),
    .biu_we      (biu_we),
    .biu_adri    (biu_adri),
    .biu_be      (biu_be),
    .biu_di      (biu_di),
    .biu_stb_ack (biu_stb_ack),
    .biu_wack    (biu_wack),
    .biu_rack    (biu_rack),
    .biu_do      (biu_do),
    .sram_en     (sram_en),
    .sram_we     (sram_we),
    .sram_addr   (sram_addr),
    .sram_be     (sram_be),
    .sram_wdata  (sram_wdata),
    .sram_rdata  (sram_rdata)
  );

  dmem_sram u_sram (
    .clk        (clk),
    .sram_en    (sram_en),
    .sram_we    (sram_we),
    .sram_addr  (sram_addr),
    .sram_be    (sram_be),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata)
  );

endmodule

`default_nettype wire

// ==== verif/dmem_sys_sva.sv ====
// Controller protocol checks on request pairing, pending writes and read ordering
`timescale 1ns/1ps
`default_nettype none

module dmem_ctrl_sva (
  input wire                          clk,
  input wire                          rstn,
  input wire                          mem_req,
  input wire                          mem_ack,
  input wire                          biu_stb,
  input wire                          biu_stb_ack,
  input wire                          biu_we,
  input wire                          biu_wack,
  input wire                          biu_rack,
  input wire  [dmem_pkg::PEND_W-1:0]  pend_cnt
);

  import dmem_pkg::*;

  // Longest wait from strobe to acknowledge
  localparam int ACK_WINDOW = 16;

  int   fail_count = 0;
  logic outstanding;
  logic accept;
  logic read_busy;

  assign accept = biu_stb & biu_stb_ack;

  // Set by the strobe, cleared by its acknowledge
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      outstanding <= 1'b0;
    else if (mem_req)
      outstanding <= 1'b1;
    else if (mem_ack)
      outstanding <= 1'b0;
  end

  // Read on the bus until its data comes back
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      read_busy <= 1'b0;
    else if (accept && !biu_we)
      read_busy <= 1'b1;
    else if (biu_rack)
      read_busy <= 1'b0;
  end

  ////////////////////////////////////////
  // CPU side pairing
  ////////////////////////////////////////

  // No acknowledge without a request, and no second one
  ack_has_request: assert property (@(posedge clk) disable iff (!rstn)
    mem_ack |-> outstanding)
    else begin $error("mem_ack without an outstanding request"); fail_count++; end

  req_gets_ack: assert property (@(posedge clk) disable iff (!rstn)
    mem_req |-> ##[1:ACK_WINDOW] mem_ack)
    else begin $error("mem_req never acknowledged"); fail_count++; end

  ////////////////////////////////////////
  // Pending writes and read order
  ////////////////////////////////////////

  pend_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
    (pend_cnt == '0) |-> !biu_wack)
    else begin $error("write done with no pending write"); fail_count++; end

  pend_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    ((pend_cnt == '1) && accept && biu_we) |-> biu_wack)
    else begin $error("pending write counter wraps"); fail_count++; end

  // Nothing goes out while a read waits for its data
  no_stb_in_read: assert property (@(posedge clk) disable iff (!rstn)
    read_busy |-> !biu_stb)
    else begin $error("biu_stb high before the read completed"); fail_count++; end

  read_after_writes: assert property (@(posedge clk) disable iff (!rstn)
    (accept && !biu_we) |-> ((pend_cnt == '0) || ((pend_cnt == PEND_W'(1)) && biu_wack)))
    else begin $error("read issued with writes in flight"); fail_count++; end

  ack_low_in_reset: assert property (@(posedge clk)
    !rstn |-> !mem_ack)
    else begin $error("mem_ack high during reset"); fail_count++; end

endmodule

bind dmem_nocache_ctrl dmem_ctrl_sva u_ctrl_sva (
  .clk         (clk),
  .rstn        (rstn),
  .mem_req     (mem_req),
  .mem_ack     (mem_ack),
  .biu_stb     (biu_stb),
  .biu_stb_ack (biu_stb_ack),
  .biu_we      (biu_we),
  .biu_wack    (biu_wack),
  .biu_rack    (biu_rack),
  .pend_cnt    (pend_cnt)
);

`default_nettype wire

// ==== verif/dmem_sys_tb.sv ====
// Data-memory subsystem testbench with directed and random loads and stores
`timescale 1ns/1ps
`default_nettype none

module dmem_sys_tb;

  import dmem_pkg::*;

  localparam int     CLK_PERIOD   = 40;
  localparam int     RESET_CYCLES = 16;
  localparam int     N_DIRECTED   = 11;
  localparam int     N_RANDOM     = 300;
  localparam int     OP_CYCLES    = 20;
  // Fill pass, directed and random operations
  localparam int     N_OPS        = MEM_WORDS + N_DIRECTED + N_RANDOM;
  localparam longint WATCHDOG_NS  = longint'(N_OPS) * OP_CYCLES * CLK_PERIOD
                                    + RESET_CYCLES * CLK_PERIOD;

  logic            clk;
  logic            rstn;
  logic            mem_req;
  logic            mem_we;
  logic [XLEN-1:0] mem_adr;
  logic [XLEN-1:0] mem_d;
  logic [BE_W-1:0] mem_be;
  logic [XLEN-1:0] mem_q;
  logic            mem_ack;

  // Byte-level reference memory
  logic [7:0]      model [MEM_WORDS*BE_W];

  integer          seed = 62270;

  dmem_sys dut (
    .clk     (clk),
    .rstn    (rstn),
    .mem_req (mem_req),
    .mem_we  (mem_we),
    .mem_adr (mem_adr),
    .mem_d   (mem_d),
    .mem_be  (mem_be),
    .mem_q   (mem_q),
    .mem_ack (mem_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  // Byte address of a word index
  function automatic logic [XLEN-1:0] word_adr(input int w);
    return XLEN'(w % MEM_WORDS) << 2;
  endfunction

  // Every byte depends on the full word index
  function automatic logic [XLEN-1:0] fill_pattern(input int w);
    logic [7:0] a;
    a = 8'(w);
    return {a, ~a, a ^ 8'h3c, a + 8'ha5};
  endfunction

  function automatic logic [XLEN-1:0] model_word(input logic [XLEN-1:0] adr);
    int              base;
    logic [XLEN-1:0] word;
    base = int'(adr[MEM_AW+1:2]) * BE_W;
    for (int b = 0; b < BE_W; b++)
      word[8*b +: 8] = model[base + b];
    return word;
  endfunction

  // Strobe for one cycle, then wait for the acknowledge
  task automatic issue_and_wait(input logic we, input logic [XLEN-1:0] adr,
                                input logic [XLEN-1:0] d, input logic [BE_W-1:0] be);
    mem_req <= 1'b1;
    mem_we  <= we;
    mem_adr <= adr;
    mem_d   <= d;
    mem_be  <= be;
    @(posedge clk);
    mem_req <= 1'b0;
    while (!mem_ack)
      @(posedge clk);
  endtask

  // Model follows the request, only enabled lanes change
  task automatic store(input logic [XLEN-1:0] adr, input logic [XLEN-1:0] d,
                       input logic [BE_W-1:0] be);
    int base;
    base = int'(adr[MEM_AW+1:2]) * BE_W;
    for (int b = 0; b < BE_W; b++)
      if (be[b])
        model[base + b] = d[8*b +: 8];
    issue_and_wait(1'b1, adr, d, be);
  endtask

  task automatic load(input logic [XLEN-1:0] adr);
    logic [XLEN-1:0] exp;
    exp = model_word(adr);
    issue_and_wait(1'b0, adr, '0, '0);
    assert (mem_q === exp)
    else
      stop_with_failure($sformatf("** Error at %0t ns: read 0x%08h expected 0x%08h got 0x%08h",
                                  $time, adr, exp, mem_q));
  endtask

  ////////////////////////////////////////
  // Watchdog and bound checks
  ////////////////////////////////////////

  initial
  begin
    #(WATCHDOG_NS);
    stop_with_failure("timeout waiting for mem_ack");
  end

  // Any bound assertion failure ends the run
  always @(posedge clk)
  begin
    if (dut.u_ctrl.u_ctrl_sva.fail_count != 0)
      stop_with_failure("controller protocol assertion failed");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin
    logic [XLEN-1:0] adr;
    rstn    = 1'b0;
    mem_req = 1'b0;
    mem_we  = 1'b0;
    mem_adr = '0;
    mem_d   = '0;
    mem_be  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    // Known contents everywhere before any read
    for (int w = 0; w < MEM_WORDS; w++)
      store(word_adr(w), fill_pattern(w), '1);

    // Full word write and read back
    store(32'h0000_0040, 32'hdead_beef, 4'hf);
    load(32'h0000_0040);

    // Partial writes merge with old bytes
    store(32'h0000_0044, 32'h1122_3344, 4'b0001);
    store(32'h0000_0044, 32'haabb_ccdd, 4'b0100);
    load(32'h0000_0044);
    store(32'h0000_0044, 32'h5566_7788, 4'b1010);
    load(32'h0000_0044);

    // Back-to-back posted writes, the read must see the last one
    store(32'h0000_0080, 32'h0101_0101, 4'hf);
    store(32'h0000_0080, 32'h0202_0202, 4'hf);
    store(32'h0000_0080, 32'h0303_0303, 4'hf);
    load(32'h0000_0080);

    // Random mix
    for (int i = 0; i < N_RANDOM; i++)
    begin
      adr = word_adr(int'({$random(seed)} % MEM_WORDS));
      if ($random(seed) & 1)
        store(adr, $random(seed), BE_W'($random(seed)));
      else
        load(adr);
    end

    repeat (4) @(posedge clk);
    if (dut.u_ctrl.u_ctrl_sva.fail_count != 0)
      stop_with_failure("controller protocol assertion failed");
    else
    begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dmem_sys.f ====
rtl/dmem_pkg.sv
rtl/dmem_sram.sv
rtl/dmem_biu.sv
rtl/dmem_nocache_ctrl.sv
rtl/dmem_sys.sv
verif/dmem_sys_sva.sv
verif/dmem_sys_tb.sv
